/* build.f */
design/crypto_cfg_pkg.sv
design/ahb_addr_decode.sv
design/cfg_write_exec.sv
design/text_block_fifo.sv
design/crypto_cfg_slave.sv
sim/tb_crypto_cfg.sv

/* design/ahb_addr_decode.sv */
`timescale 1ns/1ns

module ahb_addr_decode (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     HSELx,
  input  logic                     HWRITE,
  input  logic [31:0]              HADDR,
  input  logic [1:0]               HTRANS,
  input  logic [2:0]               HBURST,
  input  logic                     HREADY,
  output crypto_cfg_pkg::cfg_cmd_t cmd
);

  crypto_cfg_pkg::ahb_req_t req;
  crypto_cfg_pkg::cfg_cmd_t next_cmd;
  logic [7:0] key_off;
  logic [7:0] nonce_off;
  logic [7:0] text_off;
  logic       key_hit;
  logic       nonce_hit;
  logic       dest_hit;
  logic       text_hit;
  logic       mapped;

  // Word-aligned offset inside a four-word group
  function automatic logic group_hit(input logic [7:0] off);
    return (off[7:4] == 4'h0) && (off[1:0] == 2'b00);
  endfunction

  // Only the low address byte is decoded
  assign req = '{sel: HSELx, write: HWRITE, trans: HTRANS, burst: HBURST,
                 addr: HADDR[7:0]};

  assign key_off   = req.addr - crypto_cfg_pkg::KEY_BASE;
  assign nonce_off = req.addr - crypto_cfg_pkg::NONCE_BASE;
  assign text_off  = req.addr - crypto_cfg_pkg::TEXT_BASE;

  assign key_hit   = group_hit(key_off);
  assign nonce_hit = group_hit(nonce_off);
  assign text_hit  = group_hit(text_off);
  assign dest_hit  = (req.addr == crypto_cfg_pkg::DEST_ADDR);
  assign mapped    = key_hit | nonce_hit | text_hit | dest_hit;

  always_comb begin
    next_cmd = crypto_cfg_pkg::CMD_NONE;
    case (req.trans)
      crypto_cfg_pkg::TRANS_IDLE: next_cmd.op = crypto_cfg_pkg::OP_NONE;
      crypto_cfg_pkg::TRANS_BUSY,
      crypto_cfg_pkg::TRANS_SEQ: next_cmd.op = crypto_cfg_pkg::OP_ERR;
      default: begin
        // NONSEQ, check burst, direction and map
        if (req.burst != crypto_cfg_pkg::BURST_SINGLE || !req.write || !mapped) begin
          next_cmd.op = crypto_cfg_pkg::OP_ERR;
        end else if (key_hit) begin
          next_cmd.op   = crypto_cfg_pkg::OP_KEY;
          next_cmd.lane = key_off[3:2];
        end else if (nonce_hit) begin
          next_cmd.op   = crypto_cfg_pkg::OP_NONCE;
          next_cmd.lane = nonce_off[3:2];
        end else if (text_hit) begin
          next_cmd.op   = crypto_cfg_pkg::OP_TEXT;
          next_cmd.lane = text_off[3:2];
        end else begin
          next_cmd.op = crypto_cfg_pkg::OP_DEST;
        end
      end
    endcase
  end

  // Command held while the data phase is stretched
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cmd <= crypto_cfg_pkg::CMD_NONE;
    end else if (HREADY) begin
      if (req.sel) begin
        cmd <= next_cmd;
      end else begin
        cmd <= crypto_cfg_pkg::CMD_NONE;
      end
    end
  end

  a_op_defined: assert property (@(posedge HCLK) disable iff (!HRESETn)
    cmd.op inside {crypto_cfg_pkg::OP_NONE, crypto_cfg_pkg::OP_KEY,
                   crypto_cfg_pkg::OP_NONCE, crypto_cfg_pkg::OP_DEST,
                   crypto_cfg_pkg::OP_TEXT, crypto_cfg_pkg::OP_ERR});

  // Bad address surfaces as an error in the following data phase
  a_unmapped_err: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HREADY && req.sel && req.trans == crypto_cfg_pkg::TRANS_NONSEQ && !mapped)
    |=> cmd.op == crypto_cfg_pkg::OP_ERR);

endmodule

/* design/cfg_write_exec.sv */
`timescale 1ns/1ns

module cfg_write_exec (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  crypto_cfg_pkg::cfg_cmd_t    cmd,
  input  logic [31:0]                 HWDATA,
  input  logic                        fifo_full,
  output crypto_cfg_pkg::block128_t   key,
  output crypto_cfg_pkg::block128_t   nonce,
  output logic                        hready_out,
  output logic                        write_error,
  output logic                        text_push,
  output crypto_cfg_pkg::text_block_t push_block
);

  logic [31:0]               dest;
  crypto_cfg_pkg::block128_t text;
  logic                      is_text;
  logic                      text_stall;
  logic                      text_go;

  assign is_text = (cmd.op == crypto_cfg_pkg::OP_TEXT);

  // Plaintext waits for room in the queue
  assign text_stall = is_text && fifo_full;
  assign text_go    = is_text && !fifo_full;

  assign hready_out  = !text_stall;
  assign write_error = (cmd.op == crypto_cfg_pkg::OP_ERR);

  // Lane 3 completes the block
  assign text_push = text_go && (&cmd.lane);

  // Top word straight from the bus, dest as held before this edge
  always_comb begin
    push_block.text          = text;
    push_block.text[96 +: 32] = HWDATA;
    push_block.dest          = dest;
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      key   <= '0;
      nonce <= '0;
      dest  <= '0;
      text  <= '0;
    end else begin
      case (cmd.op)
        crypto_cfg_pkg::OP_KEY: begin
          key[cmd.lane * 32 +: 32] <= HWDATA;
        end
        crypto_cfg_pkg::OP_NONCE: begin
          nonce[cmd.lane * 32 +: 32] <= HWDATA;
        end
        crypto_cfg_pkg::OP_DEST: begin
          dest <= HWDATA;
        end
        crypto_cfg_pkg::OP_TEXT: begin
          // Nothing lands during a stall
          if (text_go) begin
            text[cmd.lane * 32 +: 32] <= HWDATA;
          end
        end
        default: begin
          // No state change on NONE or ERR
        end
      endcase
    end
  end

  a_push_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    text_push |-> hready_out);

  a_push_err_excl: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(text_push && write_error));

  // Decoder must keep the stalled text command alive
  a_stall_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    text_stall |=> is_text && $stable(cmd.lane));

endmodule

/* design/crypto_cfg_pkg.sv */
package crypto_cfg_pkg;

  // Register map, offsets in the low address byte
  localparam logic [7:0] KEY_BASE   = 8'h04;
  localparam logic [7:0] NONCE_BASE = 8'h14;
  localparam logic [7:0] DEST_ADDR  = 8'h24;
  localparam logic [7:0] TEXT_BASE  = 8'h34;

  // Block queue sizing
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // HTRANS encodings
  localparam logic [1:0] TRANS_IDLE   = 2'b00;
  localparam logic [1:0] TRANS_BUSY   = 2'b01;
  localparam logic [1:0] TRANS_NONSEQ = 2'b10;
  localparam logic [1:0] TRANS_SEQ    = 2'b11;

  // Only HBURST value accepted
  localparam logic [2:0] BURST_SINGLE = 3'b000;

  // Key, nonce and plaintext, lane 0 in the low word
  typedef logic [127:0] block128_t;

  // Data-phase operations
  typedef enum logic [2:0] {
    OP_NONE,
    OP_KEY,
    OP_NONCE,
    OP_DEST,
    OP_TEXT,
    OP_ERR
  } cfg_op_t;

  // Address phase as sampled from the bus
  typedef struct packed {
    logic       sel;
    logic       write;
    logic [1:0] trans;
    logic [2:0] burst;
    logic [7:0] addr;
  } ahb_req_t;

  // Decode to execute handoff
  typedef struct packed {
    cfg_op_t    op;
    logic [1:0] lane;
  } cfg_cmd_t;

  localparam cfg_cmd_t CMD_NONE = '{op: OP_NONE, lane: 2'd0};

  // Finished plaintext with its destination
  typedef struct packed {
    block128_t   text;
    logic [31:0] dest;
  } text_block_t;

endpackage

/* design/crypto_cfg_slave.sv */
`timescale 1ns/1ns

module crypto_cfg_slave (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        HSELx,
  input  logic                        HWRITE,
  input  logic [31:0]                 HADDR,
  input  logic [1:0]                  HTRANS,
  input  logic [2:0]                  HBURST,
  input  logic                        HREADY,
  input  logic [31:0]                 HWDATA,
  output logic                        hready_out,
  output logic                        write_error,
  output crypto_cfg_pkg::block128_t   key,
  output crypto_cfg_pkg::block128_t   nonce,
  output logic                        block_valid,
  output crypto_cfg_pkg::text_block_t block,
  input  logic                        block_pop
);

  // Decode to execute
  crypto_cfg_pkg::cfg_cmd_t    cmd;
  // Execute to queue
  logic                        text_push;
  crypto_cfg_pkg::text_block_t push_block;
  logic                        fifo_full;

  ahb_addr_decode u_decode (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HSELx   (HSELx),
    .HWRITE  (HWRITE),
    .HADDR   (HADDR),
    .HTRANS  (HTRANS),
    .HBURST  (HBURST),
    .HREADY  (HREADY),
    .cmd     (cmd)
  );

  cfg_write_exec u_exec (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .cmd         (cmd),
    .HWDATA      (HWDATA),
    .fifo_full   (fifo_full),
    .key         (key),
    .nonce       (nonce),
    .hready_out  (hready_out),
    .write_error (write_error),
    .text_push   (text_push),
    .push_block  (push_block)
  );

  text_block_fifo u_fifo (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .push        (text_push),
    .push_block  (push_block),
    .pop         (block_pop),
    .fifo_full   (fifo_full),
    .block_valid (block_valid),
    .block       (block)
  );

endmodule

/* design/text_block_fifo.sv */
`timescale 1ns/1ns

module text_block_fifo (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        push,
  input  crypto_cfg_pkg::text_block_t push_block,
  input  logic                        pop,
  output logic                        fifo_full,
  output logic                        block_valid,
  output crypto_cfg_pkg::text_block_t block
);

  crypto_cfg_pkg::text_block_t mem [crypto_cfg_pkg::FIFO_DEPTH];
  logic [crypto_cfg_pkg::PTR_W-1:0] wr_ptr;
  logic [crypto_cfg_pkg::PTR_W-1:0] rd_ptr;
  logic [crypto_cfg_pkg::CNT_W-1:0] count;
  logic                             do_pop;

  assign fifo_full   = (count == crypto_cfg_pkg::FIFO_DEPTH);
  assign block_valid = (count != '0);
  assign block       = mem[rd_ptr];

  // Pop on an empty queue is ignored
  assign do_pop = pop && block_valid;

  // Payload storage
  always_ff @(posedge HCLK) begin
    if (push) begin
      mem[wr_ptr] <= push_block;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Wrap at the last slot
        if (wr_ptr == crypto_cfg_pkg::PTR_W'(crypto_cfg_pkg::FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr == crypto_cfg_pkg::PTR_W'(crypto_cfg_pkg::FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Simultaneous push and pop leaves count alone
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(push && fifo_full));

  a_no_pop_empty: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(pop && !block_valid));

endmodule

/* run.sh */
#!/bin/sh
# Build and run the regression with Verilator, verdict from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_crypto_cfg -o tb_crypto_cfg \
  && ./obj_dir/tb_crypto_cfg | tee /dev/stderr | grep -q "Regression passed" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* sim/tb_crypto_cfg.sv */
`timescale 1ns/1ns

module tb_crypto_cfg;

  logic                        HCLK;
  logic                        HRESETn;
  logic                        HSELx;
  logic                        HWRITE;
  logic [31:0]                 HADDR;
  logic [1:0]                  HTRANS;
  logic [2:0]                  HBURST;
  logic [31:0]                 HWDATA;
  logic                        block_pop;
  logic                        hready_out;
  logic                        write_error;
  logic                        block_valid;
  crypto_cfg_pkg::block128_t   key;
  crypto_cfg_pkg::block128_t   nonce;
  crypto_cfg_pkg::text_block_t block;

  // Reference model state
  crypto_cfg_pkg::block128_t   exp_key;
  crypto_cfg_pkg::block128_t   exp_nonce;
  crypto_cfg_pkg::block128_t   exp_text;
  logic [31:0]                 exp_dest;
  crypto_cfg_pkg::text_block_t exp_q[$];
  logic [31:0]                 lfsr;
  int                          step;

  // HREADY fed back from the single slave
  crypto_cfg_slave dut_i (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSELx       (HSELx),
    .HWRITE      (HWRITE),
    .HADDR       (HADDR),
    .HTRANS      (HTRANS),
    .HBURST      (HBURST),
    .HREADY      (hready_out),
    .HWDATA      (HWDATA),
    .hready_out  (hready_out),
    .write_error (write_error),
    .key         (key),
    .nonce       (nonce),
    .block_valid (block_valid),
    .block       (block),
    .block_pop   (block_pop)
  );

  always #20 HCLK = ~HCLK;

  // Galois LFSR stepped once per bit with taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // Low address bytes outside the register map
  function automatic logic [7:0] unmapped_addr(input logic [2:0] idx);
    case (idx)
      3'd0:    return 8'h00;
      3'd1:    return 8'h28;
      3'd2:    return 8'h2C;
      3'd3:    return 8'h30;
      3'd4:    return 8'h44;
      3'd5:    return 8'h06;
      3'd6:    return 8'h1A;
      default: return 8'hFC;
    endcase
  endfunction

  task automatic check_block128(input string name, input crypto_cfg_pkg::block128_t exp,
                                input crypto_cfg_pkg::block128_t act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_block(input crypto_cfg_pkg::text_block_t exp,
                             input crypto_cfg_pkg::text_block_t act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns block expected %h actual %h", $time, exp, act);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_error(input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns write_error expected %b actual %b", $time, exp, act);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // Single-bit status levels
  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Called at a falling edge
  task automatic wait_block_valid();
    int n;
    n = 0;
    while (block_valid !== 1'b1) begin
      if (n == 50) stop_on_timeout("block_valid never rose");
      n++;
      @(negedge HCLK);
    end
  endtask

  // Checks the head and pulses one pop, returning just after the popping edge
  task automatic pop_block();
    wait_block_valid();
    check_block(exp_q[0], block);
    @(posedge HCLK);
    block_pop <= 1'b1;
    @(posedge HCLK);
    block_pop <= 1'b0;
    void'(exp_q.pop_front());
  endtask

  task automatic do_transfer(input logic [1:0] trans, input logic [2:0] burst, input logic wr,
                             input logic [7:0] addr, input logic [1:0] lane,
                             input logic [31:0] data, input crypto_cfg_pkg::cfg_op_t op);
    int waits;
    crypto_cfg_pkg::text_block_t blk;
    // Address phase
    @(posedge HCLK);
    HSELx  <= 1'b1;
    HTRANS <= trans;
    HBURST <= burst;
    HWRITE <= wr;
    HADDR  <= {24'(take_bits(24)), addr};
    // Data phase with the bus idle behind it
    @(posedge HCLK);
    HSELx  <= 1'b0;
    HTRANS <= crypto_cfg_pkg::TRANS_IDLE;
    HWDATA <= data;
    @(negedge HCLK);
    check_error(op == crypto_cfg_pkg::OP_ERR, write_error);
    check_level("hready_out",
                !(op == crypto_cfg_pkg::OP_TEXT && exp_q.size() == crypto_cfg_pkg::FIFO_DEPTH),
                hready_out);
    // A pop frees one slot for a stalled text write
    waits = 0;
    while (hready_out !== 1'b1) begin
      waits++;
      if (waits > 20) stop_on_timeout("hready_out stuck low");
      if (waits == 2) pop_block();
      @(negedge HCLK);
    end
    @(posedge HCLK);
    case (op)
      crypto_cfg_pkg::OP_KEY:   exp_key[32 * int'(lane) +: 32] = data;
      crypto_cfg_pkg::OP_NONCE: exp_nonce[32 * int'(lane) +: 32] = data;
      crypto_cfg_pkg::OP_DEST:  exp_dest = data;
      crypto_cfg_pkg::OP_TEXT: begin
        exp_text[32 * int'(lane) +: 32] = data;
        // Last lane sends the whole block with the current destination
        if (lane == 2'd3) begin
          blk.text = exp_text;
          blk.dest = exp_dest;
          exp_q.push_back(blk);
        end
      end
      default: begin
      end
    endcase
    // Registers visible one cycle after the data phase
    @(negedge HCLK);
    check_block128("key", exp_key, key);
    check_block128("nonce", exp_nonce, nonce);
    check_level("block_valid", exp_q.size() != 0, block_valid);
    if (exp_q.size() != 0) check_block(exp_q[0], block);
  endtask

  task automatic run_step(input logic pop_en);
    logic [2:0]              kind;
    logic [2:0]              bad;
    logic [1:0]              lane;
    logic [1:0]              trans;
    logic [2:0]              burst;
    logic                    wr;
    logic [7:0]              addr;
    crypto_cfg_pkg::cfg_op_t op;
    kind  = 3'(take_bits(3));
    lane  = 2'(take_bits(2));
    trans = crypto_cfg_pkg::TRANS_NONSEQ;
    burst = crypto_cfg_pkg::BURST_SINGLE;
    wr    = 1'b1;
    addr  = crypto_cfg_pkg::KEY_BASE + {4'h0, lane, 2'b00};
    case (kind)
      3'd0: op = crypto_cfg_pkg::OP_KEY;
      3'd1: begin
        op   = crypto_cfg_pkg::OP_NONCE;
        addr = crypto_cfg_pkg::NONCE_BASE + {4'h0, lane, 2'b00};
      end
      3'd2: begin
        op   = crypto_cfg_pkg::OP_DEST;
        addr = crypto_cfg_pkg::DEST_ADDR;
      end
      3'd3, 3'd4, 3'd5: begin
        op   = crypto_cfg_pkg::OP_TEXT;
        addr = crypto_cfg_pkg::TEXT_BASE + {4'h0, lane, 2'b00};
      end
      default: begin
        // One fault per transfer on an otherwise valid key address
        op  = crypto_cfg_pkg::OP_ERR;
        bad = 3'(take_bits(3));
        case (bad)
          3'd0:    trans = crypto_cfg_pkg::TRANS_BUSY;
          3'd1:    trans = crypto_cfg_pkg::TRANS_SEQ;
          3'd2:    burst = {1'b1, lane};
          3'd3:    wr = 1'b0;
          default: addr = unmapped_addr(3'(take_bits(3)));
        endcase
      end
    endcase
    do_transfer(trans, burst, wr, addr, lane, take_bits(32), op);
    // No error expected during the idle gap
    repeat (int'(take_bits(2))) begin
      @(negedge HCLK);
      check_error(1'b0, write_error);
    end
    if (pop_en && take_bits(2) == 32'd0 && exp_q.size() != 0) begin
      pop_block();
      @(negedge HCLK);
    end
  endtask

  initial begin
    lfsr      = 32'h8838;
    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    HSELx     = 1'b0;
    HWRITE    = 1'b0;
    HADDR     = '0;
    HTRANS    = crypto_cfg_pkg::TRANS_IDLE;
    HBURST    = crypto_cfg_pkg::BURST_SINGLE;
    HWDATA    = '0;
    block_pop = 1'b0;
    exp_key   = '0;
    exp_nonce = '0;
    exp_text  = '0;
    exp_dest  = '0;
    repeat (4) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_block128("key", '0, key);
    check_block128("nonce", '0, nonce);
    check_level("block_valid", 1'b0, block_valid);
    check_level("hready_out", 1'b1, hready_out);
    check_error(1'b0, write_error);
    // Pops withheld at first so the queue fills and stalls
    for (step = 0; step < 400; step++) begin
      run_step(step >= 150);
    end
    // Drain what is left in write order
    while (exp_q.size() != 0) begin
      pop_block();
      @(negedge HCLK);
    end
    check_level("block_valid", 1'b0, block_valid);
    $display("Regression passed");
    $finish;
  end

endmodule
